// ==== all.f ====
+incdir+testbench
logic/video_geom_pkg.sv
logic/sprite_pkg.sv
logic/pipe_stage.sv
logic/sprite_snapshot.sv
logic/region_scanner.sv
logic/write_composer.sv
logic/fb_update_top.sv
testbench/fb_update_asserts.sv
testbench/tb_fb_update.sv

// ==== logic/fb_update_top.sv ====
/* framebuffer update top
   snapshot, region scan, probe and write record stream for the changed regions */
`timescale 1ns/1ps
`default_nettype none

module fb_update_top (
    input  wire                           vgaclk,
    input  wire                           rst,
    input  wire                           frame_tick,
    input  wire                           write_bank,
    input  wire sprite_pkg::sprite_word_t blinky_in,
    input  wire sprite_pkg::sprite_word_t pinky_in,
    input  wire sprite_pkg::sprite_word_t inky_in,
    input  wire sprite_pkg::sprite_word_t clyde_in,
    input  wire sprite_pkg::sprite_word_t player_in,
    output video_geom_pkg::coord_t        probe_x,
    output video_geom_pkg::coord_t        probe_y,
    input  wire video_geom_pkg::color_t   blinky_color,
    input  wire video_geom_pkg::color_t   pinky_color,
    input  wire video_geom_pkg::color_t   inky_color,
    input  wire video_geom_pkg::color_t   clyde_color,
    input  wire video_geom_pkg::color_t   player_color,
    input  wire video_geom_pkg::color_t   maze_color,
    input  wire video_geom_pkg::color_t   score_color,
    output logic                          wr_valid,
    input  wire                           wr_ready,
    output video_geom_pkg::fb_addr_t      wr_addr,
    output video_geom_pkg::color_t        wr_color,
    output logic                          busy
);

    sprite_pkg::sprite_word_t    cur_words [sprite_pkg::SPRITE_COUNT];
    sprite_pkg::sprite_word_t    prev_words [sprite_pkg::SPRITE_COUNT];
    logic                        pt_valid;
    logic                        pt_ready;
    video_geom_pkg::scan_point_t pt_data;
    logic                        probe_valid;
    logic                        probe_ready;
    video_geom_pkg::scan_point_t probe_point;
    video_geom_pkg::fb_write_t   composed;
    video_geom_pkg::fb_write_t   wr_record;

    sprite_snapshot sprite_snapshot_inst (
        .vgaclk     (vgaclk),
        .rst        (rst),
        .frame_tick (frame_tick),
        .write_bank (write_bank),
        .blinky_in  (blinky_in),
        .pinky_in   (pinky_in),
        .inky_in    (inky_in),
        .clyde_in   (clyde_in),
        .player_in  (player_in),
        .cur_words  (cur_words),
        .prev_words (prev_words)
    );

    region_scanner region_scanner_inst (
        .vgaclk     (vgaclk),
        .rst        (rst),
        .frame_tick (frame_tick),
        .cur_words  (cur_words),
        .prev_words (prev_words),
        .pt_ready   (pt_ready),
        .pt_valid   (pt_valid),
        .pt_data    (pt_data),
        .busy       (busy)
    );

    // held point drives the external renderers
    pipe_stage #(.payload_t(video_geom_pkg::scan_point_t)) point_stage (
        .vgaclk    (vgaclk),
        .rst       (rst),
        .in_valid  (pt_valid),
        .in_ready  (pt_ready),
        .in_data   (pt_data),
        .out_valid (probe_valid),
        .out_ready (probe_ready),
        .out_data  (probe_point)
    );

    assign probe_x = probe_point.x;
    assign probe_y = probe_point.y;

    write_composer write_composer_inst (
        .point        (probe_point),
        .blinky_color (blinky_color),
        .pinky_color  (pinky_color),
        .inky_color   (inky_color),
        .clyde_color  (clyde_color),
        .player_color (player_color),
        .maze_color   (maze_color),
        .score_color  (score_color),
        .record       (composed)
    );

    pipe_stage #(.payload_t(video_geom_pkg::fb_write_t)) write_stage (
        .vgaclk    (vgaclk),
        .rst       (rst),
        .in_valid  (probe_valid),
        .in_ready  (probe_ready),
        .in_data   (composed),
        .out_valid (wr_valid),
        .out_ready (wr_ready),
        .out_data  (wr_record)
    );

    assign wr_addr  = wr_record.addr;
    assign wr_color = wr_record.color;

endmodule

`default_nettype wire

// ==== logic/pipe_stage.sv ====
/* pipe stage
   one-entry valid/ready register slice for any payload type */
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic [7:0]
) (
    input  wire           vgaclk,
    input  wire           rst,
    input  wire           in_valid,
    output logic          in_ready,
    input  wire payload_t in_data,
    output logic          out_valid,
    input  wire           out_ready,
    output payload_t      out_data
);

    logic     full;
    payload_t data_q;

    // accept when empty or when the held item leaves this cycle
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge vgaclk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge vgaclk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/region_scanner.sv ====
/* region scanner
   walks sprite boxes, pellet boxes and score strip, one point per accepted transfer */
`timescale 1ns/1ps
`default_nettype none

module region_scanner (
    input  wire                           vgaclk,
    input  wire                           rst,
    input  wire                           frame_tick,
    input  wire sprite_pkg::sprite_word_t cur_words [sprite_pkg::SPRITE_COUNT],
    input  wire sprite_pkg::sprite_word_t prev_words [sprite_pkg::SPRITE_COUNT],
    input  wire                           pt_ready,
    output logic                          pt_valid,
    output video_geom_pkg::scan_point_t   pt_data,
    output logic                          busy
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_BOX_NEW,
        S_BOX_OLD,
        S_PELLET,
        S_SCORE
    } region_t;

    typedef logic [$clog2(sprite_pkg::SCORE_POINTS)-1:0] count_t;
    typedef logic [$clog2(sprite_pkg::SPRITE_COUNT)-1:0] sprite_idx_t;

    region_t                  state;
    region_t                  next_state;
    count_t                   count;
    count_t                   last_idx;
    sprite_idx_t              sprite_idx;
    sprite_idx_t              next_sprite;
    sprite_pkg::sprite_word_t sel_word;
    video_geom_pkg::coord_t   box_x0;
    video_geom_pkg::coord_t   box_y0;
    video_geom_pkg::coord_t   pel_x0;
    video_geom_pkg::coord_t   pel_y0;
    logic                     accept;

    assign pt_valid = (state != S_IDLE);
    assign busy     = (state != S_IDLE);
    assign accept   = pt_valid && pt_ready;

    // box origin, wraps at 9 bits like the sprite coordinates
    assign sel_word = (state == S_BOX_OLD) ? prev_words[sprite_idx] : cur_words[sprite_idx];
    assign box_x0 = sel_word[sprite_pkg::SPRITE_X_LSB +: $bits(video_geom_pkg::coord_t)]
                    - video_geom_pkg::coord_t'(sprite_pkg::BOX_HALF);
    assign box_y0 = sel_word[sprite_pkg::SPRITE_Y_LSB +: $bits(video_geom_pkg::coord_t)]
                    - video_geom_pkg::coord_t'(sprite_pkg::BOX_HALF);

    // bit 6 picks the pellet column, bit 7 the row
    assign pel_x0 = count[6] ? video_geom_pkg::coord_t'(sprite_pkg::PELLET_X_FAR)
                             : video_geom_pkg::coord_t'(sprite_pkg::PELLET_X_NEAR);
    assign pel_y0 = count[7] ? video_geom_pkg::coord_t'(sprite_pkg::PELLET_Y_FAR)
                             : video_geom_pkg::coord_t'(sprite_pkg::PELLET_Y_NEAR);

    always_comb begin
        pt_data     = '0;
        last_idx    = count_t'(sprite_pkg::BOX_POINTS - 1);
        next_state  = state;
        next_sprite = sprite_idx;
        case (state)
            S_BOX_NEW, S_BOX_OLD: begin
                pt_data.x = box_x0 + video_geom_pkg::coord_t'(count[3:0]);
                pt_data.y = box_y0 + video_geom_pkg::coord_t'(count[7:4]);
                if (state == S_BOX_NEW) begin
                    next_state = S_BOX_OLD;
                end else if (sprite_idx == sprite_idx_t'(sprite_pkg::SPRITE_COUNT - 1)) begin
                    next_state  = S_PELLET;
                    next_sprite = '0;
                end else begin
                    next_state  = S_BOX_NEW;
                    next_sprite = sprite_idx + 1'b1;
                end
            end
            S_PELLET: begin
                pt_data.x  = pel_x0 + video_geom_pkg::coord_t'(count[2:0]);
                pt_data.y  = pel_y0 + video_geom_pkg::coord_t'(count[5:3]);
                last_idx   = count_t'(sprite_pkg::PELLET_POINTS - 1);
                next_state = S_SCORE;
            end
            S_SCORE: begin
                // seven digits of eight pixels per row
                pt_data.x  = video_geom_pkg::coord_t'(video_geom_pkg::SCORE_X_OFFSET)
                           + video_geom_pkg::coord_t'(
                                 count % count_t'(video_geom_pkg::SCORE_X_WIDTH));
                pt_data.y  = video_geom_pkg::coord_t'(video_geom_pkg::SCORE_Y_OFFSET)
                           + video_geom_pkg::coord_t'(
                                 count / count_t'(video_geom_pkg::SCORE_X_WIDTH));
                last_idx   = count_t'(sprite_pkg::SCORE_POINTS - 1);
                next_state = S_IDLE;
            end
            default: begin
                next_state = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge vgaclk) begin
        if (rst) begin
            state      <= S_IDLE;
            count      <= '0;
            sprite_idx <= '0;
        end else if (state == S_IDLE) begin
            // frame ticks during a scan are dropped
            if (frame_tick) begin
                state      <= S_BOX_NEW;
                count      <= '0;
                sprite_idx <= '0;
            end
        end else if (accept) begin
            if (count == last_idx) begin
                state      <= next_state;
                sprite_idx <= next_sprite;
                count      <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/sprite_pkg.sv ====
/* sprite package
   snapshot word layout, scan region sizes and pellet positions */
`default_nettype none

package sprite_pkg;

    // blinky, pinky, inky, clyde, player
    localparam int SPRITE_COUNT = 5;

    // x[22:14], y[13:5], low bits carry direction and animation state
    typedef logic [22:0] sprite_word_t;

    localparam int SPRITE_X_LSB = 14;
    localparam int SPRITE_Y_LSB = 5;

    // 16x16 box centred on the sprite position
    localparam int BOX_HALF   = 7;
    localparam int BOX_POINTS = 256;

    // four 8x8 pellet boxes
    localparam int PELLET_POINTS = 256;

    // 56x8 score strip
    localparam int SCORE_POINTS = 448;

    // pellet box origins
    localparam int PELLET_X_NEAR = 8;
    localparam int PELLET_X_FAR  = 224;
    localparam int PELLET_Y_NEAR = 56;
    localparam int PELLET_Y_FAR  = 224;

    // renderers return black where they draw nothing
    localparam video_geom_pkg::color_t COLOR_BLACK = 8'h00;

endpackage

`default_nettype wire

// ==== logic/sprite_snapshot.sv ====
/* sprite snapshot
   captures sprite words at each frame boundary, keeps two previous-position banks */
`timescale 1ns/1ps
`default_nettype none

module sprite_snapshot (
    input  wire                         vgaclk,
    input  wire                         rst,
    input  wire                         frame_tick,
    input  wire                         write_bank,
    input  wire sprite_pkg::sprite_word_t blinky_in,
    input  wire sprite_pkg::sprite_word_t pinky_in,
    input  wire sprite_pkg::sprite_word_t inky_in,
    input  wire sprite_pkg::sprite_word_t clyde_in,
    input  wire sprite_pkg::sprite_word_t player_in,
    output sprite_pkg::sprite_word_t    cur_words [sprite_pkg::SPRITE_COUNT],
    output sprite_pkg::sprite_word_t    prev_words [sprite_pkg::SPRITE_COUNT]
);

    sprite_pkg::sprite_word_t in_words [sprite_pkg::SPRITE_COUNT];
    sprite_pkg::sprite_word_t bank0 [sprite_pkg::SPRITE_COUNT];
    sprite_pkg::sprite_word_t bank1 [sprite_pkg::SPRITE_COUNT];
    logic                     read_bank;

    // scan order
    assign in_words[0] = blinky_in;
    assign in_words[1] = pinky_in;
    assign in_words[2] = inky_in;
    assign in_words[3] = clyde_in;
    assign in_words[4] = player_in;

    always_ff @(posedge vgaclk) begin
        if (rst) begin
            for (int i = 0; i < sprite_pkg::SPRITE_COUNT; i++) begin
                cur_words[i] <= '0;
                bank0[i]     <= '0;
                bank1[i]     <= '0;
            end
            read_bank <= 1'b0;
        end else if (frame_tick) begin
            for (int i = 0; i < sprite_pkg::SPRITE_COUNT; i++) begin
                cur_words[i] <= in_words[i];
                // outgoing frame's positions go to the bank of the buffer they were drawn into
                if (read_bank) begin
                    bank1[i] <= cur_words[i];
                end else begin
                    bank0[i] <= cur_words[i];
                end
            end
            // selector held for the whole frame
            read_bank <= write_bank;
        end
    end

    always_comb begin
        for (int i = 0; i < sprite_pkg::SPRITE_COUNT; i++) begin
            prev_words[i] = read_bank ? bank1[i] : bank0[i];
        end
    end

endmodule

`default_nettype wire

// ==== logic/video_geom_pkg.sv ====
/* video geometry package
   screen, maze band, score strip and framebuffer address layout */
`default_nettype none

package video_geom_pkg;

    // pixel coordinate, wide enough for the 320 line screen
    typedef logic [8:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } scan_point_t;

    typedef logic [15:0] fb_addr_t;

    // RGB332
    typedef logic [7:0] color_t;

    // one framebuffer write
    typedef struct packed {
        fb_addr_t addr;
        color_t   color;
    } fb_write_t;

    // maze band, stored row by row from address 0
    localparam int SCREEN_W      = 240;
    localparam int MAZE_Y_OFFSET = 24;
    localparam int MAZE_Y_HEIGHT = 264;

    // score strip sits above the maze, packed after the maze band
    localparam int SCORE_X_OFFSET = 8;
    localparam int SCORE_Y_OFFSET = 8;
    localparam int SCORE_X_WIDTH  = 56;
    localparam int SCORE_Y_HEIGHT = 8;
    localparam int SCORE_ADDR0    = 63360;

    // points outside both areas land here
    localparam int ADDR_NONE = 65535;

endpackage

`default_nettype wire

// ==== logic/write_composer.sv ====
/* write composer
   picks the top visible layer colour and maps the point to a framebuffer address */
`timescale 1ns/1ps
`default_nettype none

module write_composer (
    input  wire video_geom_pkg::scan_point_t point,
    input  wire video_geom_pkg::color_t      blinky_color,
    input  wire video_geom_pkg::color_t      pinky_color,
    input  wire video_geom_pkg::color_t      inky_color,
    input  wire video_geom_pkg::color_t      clyde_color,
    input  wire video_geom_pkg::color_t      player_color,
    input  wire video_geom_pkg::color_t      maze_color,
    input  wire video_geom_pkg::color_t      score_color,
    output video_geom_pkg::fb_write_t        record
);

    video_geom_pkg::color_t layers [7];
    logic                   in_maze;
    logic                   in_score;

    // highest priority first
    assign layers[0] = blinky_color;
    assign layers[1] = pinky_color;
    assign layers[2] = inky_color;
    assign layers[3] = clyde_color;
    assign layers[4] = player_color;
    assign layers[5] = maze_color;
    assign layers[6] = score_color;

    // walk from the bottom layer up, so the top non-black layer wins
    always_comb begin
        record.color = sprite_pkg::COLOR_BLACK;
        for (int i = 6; i >= 0; i--) begin
            if (layers[i] != sprite_pkg::COLOR_BLACK) begin
                record.color = layers[i];
            end
        end
    end

    assign in_maze = (point.y >= video_geom_pkg::coord_t'(video_geom_pkg::MAZE_Y_OFFSET))
                  && (point.y <  video_geom_pkg::coord_t'(video_geom_pkg::MAZE_Y_OFFSET
                                                        + video_geom_pkg::MAZE_Y_HEIGHT));

    assign in_score = (point.y >= video_geom_pkg::coord_t'(video_geom_pkg::SCORE_Y_OFFSET))
                   && (point.y <  video_geom_pkg::coord_t'(video_geom_pkg::SCORE_Y_OFFSET
                                                         + video_geom_pkg::SCORE_Y_HEIGHT))
                   && (point.x >= video_geom_pkg::coord_t'(video_geom_pkg::SCORE_X_OFFSET))
                   && (point.x <  video_geom_pkg::coord_t'(video_geom_pkg::SCORE_X_OFFSET
                                                         + video_geom_pkg::SCORE_X_WIDTH));

    // maze band wins over the score strip, they do not overlap anyway
    always_comb begin
        if (in_maze) begin
            record.addr = video_geom_pkg::fb_addr_t'(point.x)
                        + video_geom_pkg::fb_addr_t'(point.y
                              - video_geom_pkg::coord_t'(video_geom_pkg::MAZE_Y_OFFSET))
                          * video_geom_pkg::fb_addr_t'(video_geom_pkg::SCREEN_W);
        end else if (in_score) begin
            record.addr = video_geom_pkg::fb_addr_t'(video_geom_pkg::SCORE_ADDR0)
                        + video_geom_pkg::fb_addr_t'(point.x)
                        + video_geom_pkg::fb_addr_t'(point.y
                              - video_geom_pkg::coord_t'(video_geom_pkg::SCORE_Y_OFFSET))
                          * video_geom_pkg::fb_addr_t'(video_geom_pkg::SCORE_X_WIDTH);
        end else begin
            record.addr = video_geom_pkg::fb_addr_t'(video_geom_pkg::ADDR_NONE);
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the framebuffer update testbench with Verilator
# the run passes only when the log holds the pass message

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_fb_update -o tb_fb_update \
    && ./obj_dir/tb_fb_update > sim.log 2>&1 \
    || echo "build or simulation returned an error"

cat sim.log 2>/dev/null
grep -q "SIMULATION PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

// ==== testbench/fb_update_asserts.sv ====
/* write stream assertions
   reset, hold-until-accepted and address range on the top level write port */
`timescale 1ns/1ps
`default_nettype none

module fb_update_asserts (
    input wire                           vgaclk,
    input wire                           rst,
    input wire                           wr_valid,
    input wire                           wr_ready,
    input wire video_geom_pkg::fb_addr_t wr_addr,
    input wire video_geom_pkg::color_t   wr_color
);

    localparam int MAZE_END    = video_geom_pkg::SCREEN_W * video_geom_pkg::MAZE_Y_HEIGHT;
    localparam int SCORE_START = video_geom_pkg::SCORE_ADDR0 + video_geom_pkg::SCORE_X_OFFSET;
    localparam int SCORE_END   = SCORE_START
                               + video_geom_pkg::SCORE_X_WIDTH * video_geom_pkg::SCORE_Y_HEIGHT;

    // synchronous reset empties the write stage one edge after rst rises
    reset_quiet: assert property (@(posedge vgaclk) rst && $past(rst) |-> !wr_valid)
        else $error("wr_valid high during reset");

    hold_until_taken: assert property (@(posedge vgaclk) disable iff (rst)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr_addr) && $stable(wr_color))
        else $error("write record changed or dropped before it was accepted");

    // maze band, score strip or the no-address marker
    addr_in_range: assert property (@(posedge vgaclk) disable iff (rst)
        wr_valid |-> (int'(wr_addr) < MAZE_END)
                  || (int'(wr_addr) >= SCORE_START && int'(wr_addr) < SCORE_END)
                  || (int'(wr_addr) == video_geom_pkg::ADDR_NONE))
        else $error("write address %0d outside every region", wr_addr);

endmodule

bind fb_update_top fb_update_asserts fb_update_asserts_inst (
    .vgaclk   (vgaclk),
    .rst      (rst),
    .wr_valid (wr_valid),
    .wr_ready (wr_ready),
    .wr_addr  (wr_addr),
    .wr_color (wr_color)
);

`default_nettype wire

// ==== testbench/tb_fb_update_model.svh ====
/* testbench reference model
   LCG, renderer colour models and expected scan point, address and colour */
`ifndef TB_FB_UPDATE_MODEL_SVH
`define TB_FB_UPDATE_MODEL_SVH

function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// upper state bits, the low ones repeat with a short period
function automatic int rand_below(input int span);
    lcg_state = lcg_step(lcg_state);
    return int'(lcg_state[30:8]) % span;
endfunction

function automatic bit inside_box(input int x, input int y, input int x0, input int y0,
                                  input int size);
    return (x >= x0) && (x < x0 + size) && (y >= y0) && (y < y0 + size);
endfunction

// layers 0..6 are blinky, pinky, inky, clyde, player, maze, score
function automatic video_geom_pkg::color_t layer_color(input int layer, input int x,
                                                       input int y);
    case (layer)
        0: return inside_box(x, y, 40, 40, 64) ? 8'hE0 : 8'h00;
        1: return inside_box(x, y, 80, 80, 64) ? 8'hE3 : 8'h00;
        2: return inside_box(x, y, 120, 120, 64) ? 8'h1F : 8'h00;
        3: return inside_box(x, y, 160, 160, 64) ? 8'hF4 : 8'h00;
        4: return inside_box(x, y, 0, 200, 80) ? 8'hFC : 8'h00;
        // wall stripes across the maze band
        5: return (y >= 24 && y < 288 && x % 16 < 4) ? 8'h03 : 8'h00;
        // digit strokes in the score strip
        default: return (y >= 8 && y < 16 && x >= 8 && x < 64 && x % 8 < 3) ? 8'hFF : 8'h00;
    endcase
endfunction

function automatic video_geom_pkg::color_t ref_color(input video_geom_pkg::scan_point_t p);
    video_geom_pkg::color_t c;
    for (int layer = 0; layer < 7; layer++) begin
        c = layer_color(layer, int'(p.x), int'(p.y));
        if (c != 8'h00) begin
            return c;
        end
    end
    return 8'h00;
endfunction

function automatic video_geom_pkg::fb_addr_t ref_addr(input video_geom_pkg::scan_point_t p);
    int x;
    int y;
    x = int'(p.x);
    y = int'(p.y);
    if (y >= 24 && y < 288) begin
        return video_geom_pkg::fb_addr_t'(x + (y - 24) * 240);
    end
    if (y >= 8 && y < 16 && x >= 8 && x < 64) begin
        return video_geom_pkg::fb_addr_t'(63360 + x + (y - 8) * 56);
    end
    return 16'hFFFF;
endfunction

// new and old box per sprite, then pellets, then the score strip
function automatic video_geom_pkg::scan_point_t ref_point(input int idx);
    video_geom_pkg::scan_point_t p;
    sprite_pkg::sprite_word_t    w;
    int                          k;
    if (idx < 2560) begin
        k = idx % 256;
        w = ((idx / 256) % 2 == 1) ? frame_prev[idx / 512] : frame_cur[idx / 512];
        p.x = video_geom_pkg::coord_t'(int'(w[22:14]) - 7 + k % 16);
        p.y = video_geom_pkg::coord_t'(int'(w[13:5]) - 7 + k / 16);
    end else if (idx < 2816) begin
        k = idx - 2560;
        p.x = video_geom_pkg::coord_t'(((k / 64) % 2 == 1 ? 224 : 8) + k % 8);
        p.y = video_geom_pkg::coord_t'(((k / 128) % 2 == 1 ? 224 : 56) + (k / 8) % 8);
    end else begin
        k = idx - 2816;
        p.x = video_geom_pkg::coord_t'(8 + k % 56);
        p.y = video_geom_pkg::coord_t'(8 + k / 56);
    end
    return p;
endfunction

`endif

// ==== testbench/tb_fb_update.sv ====
/* framebuffer update testbench
   random sprite frames checked against a reference scan and renderer models */
`timescale 1ns/1ps
`default_nettype none

module tb_fb_update;

    localparam int FRAME_POINTS  = 3264;
    localparam int FRAME_TIMEOUT = 20000;
    localparam int SPRITES       = sprite_pkg::SPRITE_COUNT;

    logic                     vgaclk;
    logic                     rst;
    logic                     frame_tick;
    logic                     write_bank;
    logic                     wr_ready;
    sprite_pkg::sprite_word_t sprite_in [SPRITES];
    video_geom_pkg::coord_t   probe_x;
    video_geom_pkg::coord_t   probe_y;
    video_geom_pkg::color_t   layer_out [7];
    logic                     wr_valid;
    video_geom_pkg::fb_addr_t wr_addr;
    video_geom_pkg::color_t   wr_color;
    logic                     busy;

    // positions last drawn into each framebuffer
    sprite_pkg::sprite_word_t drawn_ref [2][SPRITES];
    // words the running frame was scanned with
    sprite_pkg::sprite_word_t frame_cur [SPRITES];
    sprite_pkg::sprite_word_t frame_prev [SPRITES];

    logic [31:0] lcg_state;
    int          wr_count;
    int          addr_err;
    int          color_err;
    int          other_err;
    int          tests_run;
    int          tests_failed;

    `include "tb_fb_update_model.svh"

    fb_update_top fb_update_top_inst (
        .vgaclk       (vgaclk),
        .rst          (rst),
        .frame_tick   (frame_tick),
        .write_bank   (write_bank),
        .blinky_in    (sprite_in[0]),
        .pinky_in     (sprite_in[1]),
        .inky_in      (sprite_in[2]),
        .clyde_in     (sprite_in[3]),
        .player_in    (sprite_in[4]),
        .probe_x      (probe_x),
        .probe_y      (probe_y),
        .blinky_color (layer_out[0]),
        .pinky_color  (layer_out[1]),
        .inky_color   (layer_out[2]),
        .clyde_color  (layer_out[3]),
        .player_color (layer_out[4]),
        .maze_color   (layer_out[5]),
        .score_color  (layer_out[6]),
        .wr_valid     (wr_valid),
        .wr_ready     (wr_ready),
        .wr_addr      (wr_addr),
        .wr_color     (wr_color),
        .busy         (busy)
    );

    // renderers answer the probe in the same cycle
    for (genvar i = 0; i < 7; i++) begin : renderers
        assign layer_out[i] = layer_color(i, int'(probe_x), int'(probe_y));
    end

    initial begin
        vgaclk = 1'b0;
        forever #20 vgaclk = ~vgaclk;
    end

    function automatic int total_errors();
        return addr_err + color_err + other_err;
    endfunction

    task automatic check_addr(input video_geom_pkg::fb_addr_t got,
                              input video_geom_pkg::fb_addr_t want, input int idx);
        if (got !== want) begin
            $display("FAILED at %0t: write %0d address %0d, expected %0d", $time, idx, got, want);
            addr_err++;
        end
    endtask

    task automatic check_color(input video_geom_pkg::color_t got,
                               input video_geom_pkg::color_t want, input int idx);
        if (got !== want) begin
            $display("FAILED at %0t: write %0d colour %02h, expected %02h", $time, idx, got, want);
            color_err++;
        end
    endtask

    // every accepted record against the reference sequence
    always @(posedge vgaclk) begin
        video_geom_pkg::scan_point_t p;
        if (!rst && wr_valid && wr_ready) begin
            if (wr_count >= FRAME_POINTS) begin
                $display("extra write %0d after the end of the frame at %0t", wr_count, $time);
                other_err++;
            end else begin
                p = ref_point(wr_count);
                check_addr(wr_addr, ref_addr(p), wr_count);
                check_color(wr_color, ref_color(p), wr_count);
            end
            wr_count++;
        end
    end

    // old boxes are what the target framebuffer showed when it was last drawn
    task automatic start_frame(input logic bank);
        int x;
        int y;
        int low;
        @(negedge vgaclk);
        // boxes stay inside the maze band
        for (int i = 0; i < SPRITES; i++) begin
            x = 8 + rand_below(224);
            y = 31 + rand_below(249);
            low = rand_below(32);
            sprite_in[i] = {video_geom_pkg::coord_t'(x), video_geom_pkg::coord_t'(y), 5'(low)};
        end
        write_bank = bank;
        frame_tick = 1'b1;
        wr_count = 0;
        for (int i = 0; i < SPRITES; i++) begin
            frame_cur[i] = sprite_in[i];
            frame_prev[i] = drawn_ref[bank][i];
            drawn_ref[bank][i] = sprite_in[i];
        end
    endtask

    task automatic run_frame(input bit random_ready, input int tick_at);
        int cycles;
        bit ticked;
        bit done;
        cycles = 0;
        ticked = 1'b0;
        done = 1'b0;
        while (!done && cycles < FRAME_TIMEOUT) begin
            @(negedge vgaclk);
            frame_tick = 1'b0;
            wr_ready = random_ready ? (rand_below(4) != 0) : 1'b1;
            if (!ticked && tick_at >= 0 && wr_count >= tick_at) begin
                frame_tick = 1'b1;
                ticked = 1'b1;
            end
            done = (wr_count >= FRAME_POINTS) && !busy && !wr_valid;
            cycles++;
        end
        // drain window to catch late or repeated records
        repeat (10) begin
            @(negedge vgaclk);
            frame_tick = 1'b0;
            wr_ready = 1'b1;
        end
        if (!done) begin
            $display("frame did not finish within %0d cycles, %0d writes seen",
                     FRAME_TIMEOUT, wr_count);
            other_err++;
        end else if (wr_count != FRAME_POINTS) begin
            $display("frame gave %0d writes instead of %0d", wr_count, FRAME_POINTS);
            other_err++;
        end
    endtask

    task automatic finish_test(input string name, input int errs);
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s (%0d errors)", tests_run, name,
                 (errs == 0) ? "ok" : "failed", errs);
    endtask

    initial begin
        int e0;
        int a0;
        int c0;
        rst = 1'b1;
        frame_tick = 1'b0;
        write_bank = 1'b0;
        wr_ready = 1'b1;
        lcg_state = 32'd36;
        wr_count = 0;
        addr_err = 0;
        color_err = 0;
        other_err = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int i = 0; i < SPRITES; i++) begin
            sprite_in[i] = '0;
            drawn_ref[0][i] = '0;
            drawn_ref[1][i] = '0;
        end
        repeat (8) @(negedge vgaclk);
        rst = 1'b0;

        e0 = total_errors();
        repeat (20) begin
            @(negedge vgaclk);
            if (wr_valid !== 1'b0 || busy !== 1'b0) begin
                $display("wr_valid or busy high while idle after reset at %0t", $time);
                other_err++;
            end
        end
        finish_test("idle after reset", total_errors() - e0);

        // first frame, old boxes come from the cleared bank
        e0 = other_err;
        a0 = addr_err;
        c0 = color_err;
        start_frame(1'b0);
        run_frame(1'b0, -1);
        finish_test("first frame addresses", addr_err - a0 + other_err - e0);
        finish_test("first frame colours", color_err - c0);

        e0 = total_errors();
        start_frame(1'b1);
        run_frame(1'b1, -1);
        finish_test("random back-pressure", total_errors() - e0);

        e0 = total_errors();
        start_frame(1'b0);
        run_frame(1'b0, -1);
        start_frame(1'b1);
        run_frame(1'b0, -1);
        start_frame(1'b0);
        run_frame(1'b0, -1);
        finish_test("bank alternation", total_errors() - e0);

        // tick lands in the score strip, after every sprite box
        e0 = total_errors();
        start_frame(1'b1);
        run_frame(1'b0, 2900);
        finish_test("tick during scan", total_errors() - e0);

        $display("tests %0d, failed %0d, address errors %0d, colour errors %0d, other %0d",
                 tests_run, tests_failed, addr_err, color_err, other_err);
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
